// File: bank_memory.sv
`default_nettype none

module bank_memory (
   input  logic                            clk,
   input  logic                            rst,
   input  cache_pkg::mem_req_t             mem_req,
   output logic [cache_pkg::DATA_W-1:0]    rdata,
   output logic                            mem_stall,
   output logic                            ready,
   output logic [cache_pkg::NUM_BANKS-1:0] busy
);

   logic [cache_pkg::DATA_W-1:0] mem [cache_pkg::NUM_BANKS][2 ** cache_pkg::ROW_W];
   logic [cache_pkg::BUSY_W-1:0] busy_cnt [cache_pkg::NUM_BANKS];
   logic [cache_pkg::BANK_W-1:0] bank;
   logic [cache_pkg::ROW_W-1:0]  row;
   logic [cache_pkg::ROW_W-1:0]  sweep_row;
   logic sweeping;
   logic access;
   logic accept;

   initial begin
      for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
         for (int r = 0; r < 2 ** cache_pkg::ROW_W; r++) begin
            mem[b][r] = cache_pkg::DATA_W'(r * cache_pkg::NUM_BANKS + b) ^ cache_pkg::MEM_SEED;
         end
      end
   end

   assign bank      = mem_req.addr[cache_pkg::BANK_W-1:0]; // Low bits pick the bank
   assign row       = mem_req.addr[cache_pkg::ADDR_W-1:cache_pkg::BANK_W];
   assign ready     = ~sweeping;
   assign access    = mem_req.rd | mem_req.wr;
   assign mem_stall = access & (busy[bank] | sweeping);
   assign accept    = access & ~mem_stall;
   assign rdata     = mem[bank][row];

   always_comb begin
      for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
         busy[b] = (busy_cnt[b] != '0);
      end
   end

   always_ff @(posedge clk) begin
      for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
         if (rst) begin
            busy_cnt[b] <= '0;
         end else if (accept && bank == cache_pkg::BANK_W'(b)) begin
            busy_cnt[b] <= cache_pkg::BUSY_W'(cache_pkg::BANK_BUSY_CYCLES);
         end else if (busy[b]) begin
            busy_cnt[b] <= busy_cnt[b] - 1'b1;
         end
      end
   end

   // Reset sweep restores the seeded contents, one row of every bank per cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         sweeping  <= 1'b1;
         sweep_row <= '0;
      end else if (sweeping) begin
         sweep_row <= sweep_row + 1'b1;
         if (sweep_row == '1) begin
            sweeping <= 1'b0;
         end
      end
   end

   always @(posedge clk) begin
      if (sweeping) begin
         for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
            mem[b][sweep_row] <= {sweep_row, cache_pkg::BANK_W'(b)} ^ cache_pkg::MEM_SEED;
         end
      end else if (accept && mem_req.wr) begin
         mem[bank][row] <= mem_req.wdata;
      end
   end

   // Requester repeats a stalled access unchanged
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      mem_stall |=> access && mem_req.addr == $past(mem_req.addr));

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`default_nettype none

module cache_ctrl (
   input  logic                           clk,
   input  logic                           rst,
   input  cache_pkg::cache_req_t          req,
   input  logic                           hit,
   input  logic                           valid,
   input  logic                           dirty,
   input  logic                           mem_stall,
   input  logic                           ready,
   input  logic [cache_pkg::OFFSET_W-1:0] cnt,
   output logic                           done,
   output logic                           cache_hit,
   output logic                           stall,
   output logic                           comp,
   output logic                           en,
   output logic                           cache_wr,
   output logic                           mem_rd,
   output logic                           mem_wr,
   output logic                           inc,
   output logic                           err
);

   cache_pkg::ctrl_state_t state;
   cache_pkg::ctrl_state_t nxt_state;
   logic state_err;
   logic line_hit;
   logic last_word;

   assign line_hit  = hit & valid;
   assign last_word = (cnt == cache_pkg::LAST_WORD) & ~mem_stall; // Final word accepted
   assign err       = $isunknown(req) | state_err;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= cache_pkg::IDLE;
      end else begin
         state <= nxt_state;
      end
   end

   always_comb begin
      done      = 1'b0;
      cache_hit = 1'b0;
      stall     = 1'b1;
      comp      = 1'b0;
      en        = 1'b0;
      cache_wr  = 1'b0;
      mem_rd    = 1'b0;
      mem_wr    = 1'b0;
      inc       = 1'b0;
      state_err = 1'b0;
      nxt_state = state;

      case (state)
         cache_pkg::IDLE: begin
            if (ready && (req.read || req.write)) begin
               en   = 1'b1;
               comp = 1'b1;
               if (line_hit) begin
                  cache_hit = 1'b1;
                  done      = 1'b1;
                  stall     = 1'b0;
                  cache_wr  = req.write;
               end else begin
                  nxt_state = cache_pkg::ACCESS_RD;
               end
            end else begin
               stall = ~ready; // Memory still sweeping after reset
            end
         end
         cache_pkg::ACCESS_RD: begin
            en        = 1'b1;
            nxt_state = (valid && dirty) ? cache_pkg::MEM_WR_1 : cache_pkg::MEM_RD_1;
         end
         cache_pkg::MEM_WR_1: begin
            // Write back the victim line
            en     = 1'b1;
            mem_wr = 1'b1;
            inc    = ~mem_stall;
            if (last_word) begin
               nxt_state = cache_pkg::MEM_RD_1;
            end
         end
         cache_pkg::MEM_RD_1: begin
            mem_rd   = 1'b1;
            en       = ~mem_stall;
            cache_wr = ~mem_stall;
            inc      = ~mem_stall;
            if (!mem_stall) begin
               nxt_state = cache_pkg::MEM_RD_2;
            end
         end
         cache_pkg::MEM_RD_2: begin
            mem_rd   = 1'b1;
            en       = ~mem_stall;
            cache_wr = ~mem_stall;
            inc      = ~mem_stall;
            if (last_word) begin
               nxt_state = cache_pkg::ACCESS_WR_2;
            end
         end
         cache_pkg::ACCESS_WR_2: begin
            en        = 1'b1;
            nxt_state = req.write ? cache_pkg::CMP_WR : cache_pkg::CMP_RD;
         end
         cache_pkg::CMP_WR: begin
            en   = 1'b1;
            comp = 1'b1;
            if (line_hit) begin
               cache_wr  = 1'b1; // Store the client word into the new line
               nxt_state = cache_pkg::ACCESS_WR;
            end else begin
               nxt_state = cache_pkg::ACCESS_RD;
            end
         end
         cache_pkg::CMP_RD: begin
            en        = 1'b1;
            comp      = 1'b1;
            nxt_state = line_hit ? cache_pkg::ACCESS_WR : cache_pkg::ACCESS_RD;
         end
         cache_pkg::ACCESS_WR: begin
            en        = 1'b1;
            done      = 1'b1;
            stall     = 1'b0;
            nxt_state = cache_pkg::IDLE;
         end
         default: begin
            state_err = 1'b1;
            nxt_state = cache_pkg::IDLE;
         end
      endcase
   end

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr));

   a_done_state: assert property (@(posedge clk) disable iff (rst)
      done |-> (state == cache_pkg::IDLE || state == cache_pkg::ACCESS_WR));

endmodule

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

   // Geometry
   localparam int ADDR_W    = 16;
   localparam int DATA_W    = 16;
   localparam int OFFSET_W  = 2;   // 4 words per line
   localparam int INDEX_W   = 4;   // 16 lines
   localparam int TAG_W     = ADDR_W - INDEX_W - OFFSET_W;
   localparam int LINES     = 2 ** INDEX_W;
   localparam int CACHE_WORDS = LINES * (2 ** OFFSET_W);
   localparam logic [OFFSET_W-1:0] LAST_WORD = '1;

   // Backing memory
   localparam int NUM_BANKS        = 4;
   localparam int BANK_W           = $clog2(NUM_BANKS);
   localparam int ROW_W            = ADDR_W - BANK_W;
   localparam int BANK_BUSY_CYCLES = 2;
   localparam int BUSY_W           = $clog2(BANK_BUSY_CYCLES + 1);
   localparam logic [DATA_W-1:0] MEM_SEED = 16'hA5C3;

   typedef enum logic [3:0] {
      IDLE        = 4'b0000,
      CMP_WR      = 4'b0001,
      CMP_RD      = 4'b0010,
      ACCESS_RD   = 4'b0011,
      MEM_WR_1    = 4'b0100,
      MEM_RD_1    = 4'b0101,
      ACCESS_WR   = 4'b0110,
      ACCESS_WR_2 = 4'b0111,
      MEM_RD_2    = 4'b1000
   } ctrl_state_t;

   typedef struct packed {
      logic              read;
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } cache_req_t;

   typedef struct packed {
      logic              rd;
      logic              wr;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

endpackage

`default_nettype wire

// File: cache_store.sv
`default_nettype none

module cache_store (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [cache_pkg::INDEX_W-1:0]  index,
   input  logic [cache_pkg::OFFSET_W-1:0] offset,
   input  logic [cache_pkg::TAG_W-1:0]    tag,
   input  logic                           en,
   input  logic                           comp,
   input  logic                           cache_wr,
   input  logic [cache_pkg::DATA_W-1:0]   wdata,
   output logic                           hit,
   output logic                           valid,
   output logic                           dirty,
   output logic [cache_pkg::TAG_W-1:0]    victim_tag,
   output logic [cache_pkg::DATA_W-1:0]   rdata
);

   logic [cache_pkg::TAG_W-1:0]  tag_arr  [cache_pkg::LINES];
   logic [cache_pkg::DATA_W-1:0] data_arr [cache_pkg::CACHE_WORDS];
   logic [cache_pkg::LINES-1:0]  valid_arr;
   logic [cache_pkg::LINES-1:0]  dirty_arr;
   logic wr_cmp;
   logic wr_fill;
   logic fill_last;

   assign wr_cmp    = en & cache_wr & comp;   // Client write
   assign wr_fill   = en & cache_wr & ~comp;  // Line fill from memory
   assign fill_last = wr_fill & (offset == cache_pkg::LAST_WORD);

   assign victim_tag = tag_arr[index];
   assign valid      = valid_arr[index];
   assign dirty      = dirty_arr[index];
   assign hit        = en & (tag_arr[index] == tag);
   assign rdata      = data_arr[{index, offset}];

   always_ff @(posedge clk) begin
      if (wr_cmp || wr_fill) begin
         data_arr[{index, offset}] <= wdata;
      end
      // Tag switches once the whole line has arrived
      if (wr_cmp || fill_last) begin
         tag_arr[index] <= tag;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_arr <= '0;
         dirty_arr <= '0;
      end else if (wr_cmp) begin
         valid_arr[index] <= 1'b1;
         dirty_arr[index] <= 1'b1;
      end else if (fill_last) begin
         valid_arr[index] <= 1'b1;
         dirty_arr[index] <= 1'b0;
      end
   end

   a_wr_needs_en: assert property (@(posedge clk) disable iff (rst) cache_wr |-> en);

endmodule

`default_nettype wire

// File: cache_system.f
cache_pkg.sv
cache_ctrl.sv
cache_store.sv
line_sequencer.sv
bank_memory.sv
cache_system.sv
tb_cache_system.sv

// File: cache_system.sv
`default_nettype none

module cache_system (
   input  logic                            clk,
   input  logic                            rst,
   input  cache_pkg::cache_req_t           req,
   output logic [cache_pkg::DATA_W-1:0]    rdata,
   output logic                            done,
   output logic                            cache_hit,
   output logic                            stall,
   output logic                            err,
   output logic [cache_pkg::NUM_BANKS-1:0] busy
);

   logic hit;
   logic valid;
   logic dirty;
   logic mem_stall;
   logic ready;
   logic en;
   logic comp;
   logic cache_wr;
   logic mem_rd;
   logic mem_wr;
   logic inc;
   logic [cache_pkg::OFFSET_W-1:0] cnt;
   logic [cache_pkg::OFFSET_W-1:0] store_offset;
   logic [cache_pkg::TAG_W-1:0]    victim_tag;
   logic [cache_pkg::DATA_W-1:0]   store_wdata;
   logic [cache_pkg::DATA_W-1:0]   mem_rdata;
   cache_pkg::mem_req_t            mem_req;

   cache_ctrl u_cache_ctrl (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .hit       (hit),
      .valid     (valid),
      .dirty     (dirty),
      .mem_stall (mem_stall),
      .ready     (ready),
      .cnt       (cnt),
      .done      (done),
      .cache_hit (cache_hit),
      .stall     (stall),
      .comp      (comp),
      .en        (en),
      .cache_wr  (cache_wr),
      .mem_rd    (mem_rd),
      .mem_wr    (mem_wr),
      .inc       (inc),
      .err       (err)
   );

   cache_store u_cache_store (
      .clk        (clk),
      .rst        (rst),
      .index      (req.addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W]),
      .offset     (store_offset),
      .tag        (req.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W]),
      .en         (en),
      .comp       (comp),
      .cache_wr   (cache_wr),
      .wdata      (store_wdata),
      .hit        (hit),
      .valid      (valid),
      .dirty      (dirty),
      .victim_tag (victim_tag),
      .rdata      (rdata)
   );

   line_sequencer u_line_sequencer (
      .clk          (clk),
      .rst          (rst),
      .req          (req),
      .victim_tag   (victim_tag),
      .inc          (inc),
      .mem_rd       (mem_rd),
      .mem_wr       (mem_wr),
      .dirty        (dirty),
      .mem_rdata    (mem_rdata),
      .store_rdata  (rdata),
      .cnt          (cnt),
      .store_offset (store_offset),
      .store_wdata  (store_wdata),
      .mem_req      (mem_req)
   );

   bank_memory u_bank_memory (
      .clk       (clk),
      .rst       (rst),
      .mem_req   (mem_req),
      .rdata     (mem_rdata),
      .mem_stall (mem_stall),
      .ready     (ready),
      .busy      (busy)
   );

endmodule

`default_nettype wire

// File: line_sequencer.sv
`default_nettype none

module line_sequencer (
   input  logic                           clk,
   input  logic                           rst,
   input  cache_pkg::cache_req_t          req,
   input  logic [cache_pkg::TAG_W-1:0]    victim_tag,
   input  logic                           inc,
   input  logic                           mem_rd,
   input  logic                           mem_wr,
   input  logic                           dirty,
   input  logic [cache_pkg::DATA_W-1:0]   mem_rdata,
   input  logic [cache_pkg::DATA_W-1:0]   store_rdata,
   output logic [cache_pkg::OFFSET_W-1:0] cnt,
   output logic [cache_pkg::OFFSET_W-1:0] store_offset,
   output logic [cache_pkg::DATA_W-1:0]   store_wdata,
   output cache_pkg::mem_req_t            mem_req
);

   logic [cache_pkg::TAG_W-1:0]   req_tag;
   logic [cache_pkg::INDEX_W-1:0] req_index;
   logic mem_act;
   logic write_back;

   assign req_tag    = req.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
   assign req_index  = req.addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
   assign mem_act    = mem_rd | mem_wr;
   assign write_back = mem_wr & dirty;

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt <= '0;
      end else if (inc) begin
         cnt <= cnt + 1'b1; // Wraps after the last word
      end
   end

   always_comb begin
      mem_req.rd    = mem_rd;
      mem_req.wr    = mem_wr;
      mem_req.wdata = store_rdata;
      if (write_back) begin
         mem_req.addr = {victim_tag, req_index, cnt};
      end else if (mem_act) begin
         mem_req.addr = {req_tag, req_index, cnt};
      end else begin
         mem_req.addr = req.addr;
      end
   end

   assign store_offset = mem_act ? cnt : req.addr[cache_pkg::OFFSET_W-1:0];
   assign store_wdata  = (req.write && !mem_act) ? req.wdata : mem_rdata;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_cache_system
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f cache_system.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

# Result comes from the log, not the exit status
if grep -qx "Simulation completed successfully" "$LOG"; then
   echo "RESULT: PASS"
   exit 0
fi
echo "RESULT: FAIL"
exit 1

// File: tb_cache_system.sv
`default_nettype none

module tb_cache_system;

   localparam int PERIOD       = 100;
   localparam int SAMPLE_DLY   = 25;    // Outputs settled, well before the rising edge
   localparam int WAIT_LIMIT   = 200;
   localparam int SWEEP_LIMIT  = 20000; // Reset sweep rewrites all 16K rows
   localparam int NUM_DIRECTED = 9;
   localparam int NUM_RANDOM   = 40;

   typedef struct packed {
      logic                         write;
      logic [cache_pkg::ADDR_W-1:0] addr;
      logic [cache_pkg::DATA_W-1:0] wdata;
      logic                         exp_hit;
      logic                         check_data;
      logic [cache_pkg::DATA_W-1:0] exp_rdata;
   } stim_t;

   logic                            clk;
   logic                            rst;
   cache_pkg::cache_req_t           req;
   logic [cache_pkg::DATA_W-1:0]    rdata;
   logic                            done;
   logic                            cache_hit;
   logic                            stall;
   logic                            err;
   logic [cache_pkg::NUM_BANKS-1:0] busy;

   stim_t stim      [NUM_DIRECTED];
   string stim_name [NUM_DIRECTED];

   // Reference model of memory contents and cache residency
   logic [cache_pkg::DATA_W-1:0] shadow_mem [2 ** cache_pkg::ADDR_W];
   logic [cache_pkg::TAG_W-1:0]  shadow_tag [cache_pkg::LINES];
   logic [cache_pkg::LINES-1:0]  shadow_valid;

   logic                         got_hit;
   logic                         got_first;
   logic [cache_pkg::DATA_W-1:0] got_rdata;
   logic                         timed_out;
   integer                       seed;
   int                           errors;
   int                           tests_run;
   int                           tests_failed;

   cache_system u_cache_system (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .rdata     (rdata),
      .done      (done),
      .cache_hit (cache_hit),
      .stall     (stall),
      .err       (err),
      .busy      (busy)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   task automatic log_mismatch(input string msg);
      errors++;
      $display("FAILED at time %0t: %s", $time, msg);
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (timed_out || errors != errors_before) begin
         tests_failed++;
         $display("test %s: failed", name);
      end else begin
         $display("test %s: passed", name);
      end
   endtask

   function automatic logic predict_hit(input logic [cache_pkg::ADDR_W-1:0] addr);
      logic [cache_pkg::INDEX_W-1:0] idx;
      idx = addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
      return shadow_valid[idx] &&
             (shadow_tag[idx] == addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W]);
   endfunction

   task automatic update_shadow(input logic write, input logic [cache_pkg::ADDR_W-1:0] addr,
                                input logic [cache_pkg::DATA_W-1:0] wdata);
      logic [cache_pkg::INDEX_W-1:0] idx;
      idx               = addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
      shadow_valid[idx] = 1'b1; // Both kinds of miss allocate
      shadow_tag[idx]   = addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
      if (write) begin
         shadow_mem[addr] = wdata;
      end
   endtask

   // One request held from a falling edge until done, then released
   task automatic run_access(input logic write, input logic [cache_pkg::ADDR_W-1:0] addr,
                             input logic [cache_pkg::DATA_W-1:0] wdata);
      int cycles;
      @(negedge clk);
      req.read  = ~write;
      req.write = write;
      req.addr  = addr;
      req.wdata = wdata;
      cycles    = 0;
      #(SAMPLE_DLY);
      while (done !== 1'b1 && cycles < WAIT_LIMIT) begin
         if (stall !== 1'b1) begin
            log_mismatch($sformatf("stall low while waiting on address %h", addr));
         end
         if (err !== 1'b0) begin
            log_mismatch($sformatf("err raised during access to %h", addr));
         end
         @(negedge clk);
         #(SAMPLE_DLY);
         cycles++;
      end
      if (done !== 1'b1) begin
         $display("Timeout: no done within %0d cycles for address %h", WAIT_LIMIT, addr);
         timed_out = 1'b1;
      end else begin
         if (stall !== 1'b0) begin
            log_mismatch($sformatf("stall high together with done, address %h", addr));
         end
         if (err !== 1'b0) begin
            log_mismatch($sformatf("err raised at done, address %h", addr));
         end
      end
      got_hit   = cache_hit;
      got_rdata = rdata;
      got_first = (cycles == 0);
      @(negedge clk);
      req = '0;
   endtask

   task automatic apply_op(input stim_t s);
      run_access(s.write, s.addr, s.wdata);
      if (!timed_out) begin
         if (got_hit !== s.exp_hit) begin
            log_mismatch($sformatf("address %h cache_hit %b, expected %b",
                                   s.addr, got_hit, s.exp_hit));
         end
         if (s.exp_hit && !got_first) begin
            log_mismatch($sformatf("hit on %h did not finish in its first cycle", s.addr));
         end
         if (s.check_data && got_rdata !== s.exp_rdata) begin
            log_mismatch($sformatf("address %h rdata %h, expected %h",
                                   s.addr, got_rdata, s.exp_rdata));
         end
         update_shadow(s.write, s.addr, s.wdata);
      end
   endtask

   task automatic load_table();
      // write, addr, wdata, exp_hit, check_data, exp_rdata
      stim[0]      = '{1'b0, 16'h0040, 16'h0000, 1'b0, 1'b1, 16'hA583};
      stim_name[0] = "cold read miss";
      stim[1]      = '{1'b0, 16'h0043, 16'h0000, 1'b1, 1'b1, 16'hA580};
      stim_name[1] = "read hit in same line";
      stim[2]      = '{1'b1, 16'h0105, 16'h1234, 1'b0, 1'b0, 16'h0000};
      stim_name[2] = "write miss allocate";
      stim[3]      = '{1'b0, 16'h0105, 16'h0000, 1'b1, 1'b1, 16'h1234};
      stim_name[3] = "read hit of written word";
      stim[4]      = '{1'b0, 16'h0145, 16'h0000, 1'b0, 1'b1, 16'hA486}; // Evicts dirty tag 4
      stim_name[4] = "read evicts dirty line";
      stim[5]      = '{1'b0, 16'h0105, 16'h0000, 1'b0, 1'b1, 16'h1234};
      stim_name[5] = "reread after write-back";
      stim[6]      = '{1'b0, 16'h0104, 16'h0000, 1'b1, 1'b1, 16'hA4C7};
      stim_name[6] = "read hit in refilled line";
      stim[7]      = '{1'b1, 16'h0106, 16'hBEEF, 1'b1, 1'b0, 16'h0000};
      stim_name[7] = "write hit";
      stim[8]      = '{1'b0, 16'h0106, 16'h0000, 1'b1, 1'b1, 16'hBEEF};
      stim_name[8] = "read after write hit";
   endtask

   initial begin
      stim_t       s;
      logic [31:0] rnd;
      int          errors_before;
      int          cycles;
      int          hits;
      req          = '0;
      rst          = 1'b1;
      timed_out    = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      seed         = 30094;
      shadow_valid = '0;
      for (int a = 0; a < 2 ** cache_pkg::ADDR_W; a++) begin
         shadow_mem[cache_pkg::ADDR_W'(a)] = cache_pkg::DATA_W'(a) ^ cache_pkg::MEM_SEED;
      end
      load_table();

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Memory reset sweep holds stall until it ends
      errors_before = errors;
      cycles        = 0;
      #(SAMPLE_DLY);
      while (stall !== 1'b0 && cycles < SWEEP_LIMIT) begin
         @(negedge clk);
         #(SAMPLE_DLY);
         cycles++;
      end
      if (stall !== 1'b0) begin
         $display("Timeout: stall still high %0d cycles after reset", SWEEP_LIMIT);
         timed_out = 1'b1;
      end else begin
         if (done !== 1'b0) begin
            log_mismatch("done high with no request after reset");
         end
         if (err !== 1'b0) begin
            log_mismatch("err high after reset");
         end
         if (busy !== '0) begin
            log_mismatch($sformatf("banks busy after reset, busy %b", busy));
         end
      end
      report_test("reset and memory sweep", errors_before);

      for (int i = 0; i < NUM_DIRECTED && !timed_out; i++) begin
         errors_before = errors;
         apply_op(stim[i]);
         report_test(stim_name[i], errors_before);
      end

      if (!timed_out) begin
         errors_before = errors;
         hits          = 0;
         for (int n = 0; n < NUM_RANDOM && !timed_out; n++) begin
            rnd          = $random(seed);
            s.write      = rnd[8];
            s.addr       = {8'h00, rnd[7:0]}; // Tags 0 to 3 over all lines
            rnd          = $random(seed);
            s.wdata      = rnd[15:0];
            s.exp_hit    = predict_hit(s.addr);
            s.check_data = ~s.write;
            s.exp_rdata  = shadow_mem[s.addr];
            if (s.exp_hit) begin
               hits++;
            end
            apply_op(s);
         end
         report_test($sformatf("random sequence of %0d accesses, %0d hits", NUM_RANDOM, hits),
                     errors_before);
      end

      $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (timed_out || errors != 0) begin
         $display("Simulation failed");
      end else begin
         $display("Simulation completed successfully");
      end
      $finish;
   end

endmodule

`default_nettype wire
